// ==== line_follower.f ====
rtl/line_follower_pkg.sv
rtl/track_sensor_sync.sv
rtl/tracker_fsm.sv
rtl/motor_pwm.sv
rtl/seven_segment.sv
rtl/line_follower_top.sv
test/tb_clock_gen.sv
test/line_follower_checker.sv
test/line_follower_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = line_follower_tb
FILELIST  = line_follower.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/line_follower_stimulus.txt ====
// columns: hold cycles, sensor bits (left mid right), start_move, reset, expected state
// all values hex; states 0 stop, 1 turn_right, 2 turn_left, 3 go_straight
30 0 0 0 0
// 110 without the start switch keeps stop
28 6 0 0 0
// start, straight, then the 110 pattern turns left with the flag clear
30 6 1 0 2
3c 7 1 0 3
// black held past the limit turns right
8c 7 1 0 1
30 2 1 0 2
// short black pulse is dropped
02 7 1 0 2
30 2 1 0 2
30 7 1 0 3
30 2 1 0 2
// restart from 011 sets the direction flag
0a 0 0 1 0
30 0 0 0 0
30 3 1 0 1
3c 7 1 0 3
8c 7 1 0 2
30 5 1 0 1
03 7 1 0 1
30 5 1 0 1
30 7 1 0 3
0 0 0 0 0

// ==== test/line_follower_tb.sv ====
`timescale 1ns/1ps

module line_follower_tb;

    // five words per step
    localparam int MAX_WORDS = 5 * 64;

    logic        clk;
    logic        por_reset;
    logic        step_reset;
    logic        dut_reset;
    logic        left_track;
    logic        mid_track;
    logic        right_track;
    logic        start_move;
    logic [1:0]  state;
    logic [1:0]  pre_state;
    logic        left_pwm;
    logic        right_pwm;
    logic [6:0]  display;
    logic [3:0]  digit;
    logic        step_valid;
    logic        step_last;
    logic [2:0]  held_sensor;
    logic        held_start;
    logic [1:0]  expected_state;
    int          step_cycle;
    int          step_hold;
    int          error_count;
    int          check_count;
    int          timeout_limit;
    int          cycle_count;
    logic [15:0] stim_mem [0:MAX_WORDS-1];

    assign dut_reset = por_reset | step_reset;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (por_reset)
    );

    line_follower_top i_line_follower_top (
        .clk         (clk),
        .reset       (dut_reset),
        .left_track  (left_track),
        .mid_track   (mid_track),
        .right_track (right_track),
        .start_move  (start_move),
        .state       (state),
        .pre_state   (pre_state),
        .left_pwm    (left_pwm),
        .right_pwm   (right_pwm),
        .display     (display),
        .digit       (digit)
    );

    line_follower_checker i_line_follower_checker (
        .clk            (clk),
        .reset          (dut_reset),
        .state          (state),
        .pre_state      (pre_state),
        .left_pwm       (left_pwm),
        .right_pwm      (right_pwm),
        .display        (display),
        .digit          (digit),
        .step_valid     (step_valid),
        .held_sensor    (held_sensor),
        .held_start     (held_start),
        .step_cycle     (step_cycle),
        .step_hold      (step_hold),
        .step_last      (step_last),
        .expected_state (expected_state),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    // one line of the stimulus file, applied on falling edges
    task automatic apply_step(input int base);
        int hold;
        hold = int'(stim_mem[base]);
        for (int c = 0; c < hold; c++) begin
            @(negedge clk);
            {left_track, mid_track, right_track} <= stim_mem[base + 1][2:0];
            held_sensor    <= stim_mem[base + 1][2:0];
            start_move     <= stim_mem[base + 2][0];
            held_start     <= stim_mem[base + 2][0];
            step_reset     <= stim_mem[base + 3][0];
            expected_state <= stim_mem[base + 4][1:0];
            step_hold      <= hold;
            step_cycle     <= c;
            step_last      <= (c == hold - 1);
            step_valid     <= 1'b1;
        end
    endtask

    initial begin : run_steps
        int idx;
        left_track     = 1'b0;
        mid_track      = 1'b0;
        right_track    = 1'b0;
        start_move     = 1'b0;
        step_reset     = 1'b0;
        step_valid     = 1'b0;
        step_last      = 1'b0;
        held_sensor    = 3'b000;
        held_start     = 1'b0;
        expected_state = 2'b00;
        step_cycle     = 0;
        step_hold      = 0;
        cycle_count    = 0;
        for (idx = 0; idx < MAX_WORDS; idx++) begin
            stim_mem[idx] = 16'h0000;
        end
        $readmemh("test/line_follower_stimulus.txt", stim_mem);
        // a zero hold ends the list
        timeout_limit = 200;
        idx = 0;
        while (idx < MAX_WORDS && stim_mem[idx] != 16'h0000) begin
            timeout_limit += int'(stim_mem[idx]);
            idx += 5;
        end
        wait (!por_reset);
        idx = 0;
        while (idx < MAX_WORDS && stim_mem[idx] != 16'h0000) begin
            apply_step(idx);
            idx += 5;
        end
        @(negedge clk);
        step_valid <= 1'b0;
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

// ==== test/line_follower_checker.sv ====
`timescale 1ns/1ps

module line_follower_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] state,
    input  logic [1:0] pre_state,
    input  logic       left_pwm,
    input  logic       right_pwm,
    input  logic [6:0] display,
    input  logic [3:0] digit,
    input  logic       step_valid,
    input  logic [2:0] held_sensor,
    input  logic       held_start,
    input  int         step_cycle,
    input  int         step_hold,
    input  logic       step_last,
    input  logic [1:0] expected_state,
    output int         error_count,
    output int         check_count
);

    localparam int ST_STOP  = 0;
    localparam int ST_RIGHT = 1;
    localparam int ST_LEFT  = 2;
    localparam int ST_FWD   = 3;

    logic       was_reset;
    logic       flag;
    logic [1:0] last_state;
    logic [3:0] last_digit;
    int         left_high;
    int         right_high;
    // state held when a short sensor pulse began
    logic       pulse_watch;
    logic [1:0] pulse_state;

    // segments gfedcba, active low
    function automatic logic [6:0] segments_for(input logic [3:0] value);
        case (value)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0010000;
            4'd10:   return 7'b0111111;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int duty_for(input int st, input logic left_wheel);
        case (st)
            ST_FWD:   return int'(line_follower_pkg::DUTY_FAST);
            ST_LEFT:  return left_wheel ? int'(line_follower_pkg::DUTY_SLOW)
                                        : int'(line_follower_pkg::DUTY_FAST);
            ST_RIGHT: return left_wheel ? int'(line_follower_pkg::DUTY_FAST)
                                        : int'(line_follower_pkg::DUTY_SLOW);
            default:  return 0;
        endcase
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        was_reset   = 1'b1;
        flag        = 1'b0;
        last_state  = 2'b00;
        last_digit  = 4'b1111;
        left_high   = 0;
        right_high  = 0;
        pulse_watch = 1'b0;
        pulse_state = 2'b00;
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : sample_outputs
        logic [3:0] next_digit;
        logic [3:0] shown;
        int         turn;
        if (reset) begin
            flag        = 1'b0;
            was_reset   = 1'b1;
            pulse_watch = 1'b0;
            if (step_valid && step_last) begin
                compare("state", int'(expected_state), int'(state));
            end
        end else begin
            if (was_reset) begin
                compare("state", ST_STOP, int'(state));
                compare("pre_state", ST_STOP, int'(pre_state));
                compare("digit", 4'b1111, int'(digit));
                compare("display", 7'b1111111, int'(display));
                compare("left_pwm", 0, int'(left_pwm));
                compare("right_pwm", 0, int'(right_pwm));
            end else begin
                if (state != last_state) begin
                    compare("pre_state", int'(last_state), int'(pre_state));
                    if (last_state == 2'(ST_STOP)) begin
                        compare("state", ST_FWD, int'(state));
                        if (!held_start) begin
                            error_count++;
                            $display("Error at %0t: car left stop while start_move was low",
                                     $time);
                        end
                    end
                    // long black follows the flag, other patterns go the other way
                    if (last_state == 2'(ST_FWD) && step_valid && step_cycle >= 6) begin
                        if (held_sensor == 3'b111) begin
                            turn = flag ? ST_LEFT : ST_RIGHT;
                        end else begin
                            turn = flag ? ST_RIGHT : ST_LEFT;
                        end
                        compare("state", turn, int'(state));
                    end
                end
                if (digit != last_digit) begin
                    case (last_digit)
                        4'b1110: next_digit = 4'b1101;
                        4'b1101: next_digit = 4'b1011;
                        4'b1011: next_digit = 4'b0111;
                        default: next_digit = 4'b1110;
                    endcase
                    compare("digit", int'(next_digit), int'(digit));
                    if (step_valid && step_cycle >= 8) begin
                        case (digit)
                            4'b1110: shown = {3'b000, held_sensor[0]};
                            4'b1101: shown = {3'b000, held_sensor[1]};
                            4'b1011: shown = {3'b000, held_sensor[2]};
                            4'b0111: shown = {2'b00, last_state};
                            default: shown = 4'hf;
                        endcase
                        compare("display", int'(segments_for(shown)), int'(display));
                    end
                end
            end
            if (step_valid) begin
                if (step_cycle == 0) begin
                    left_high  = 0;
                    right_high = 0;
                end
                // last full pwm period of the step
                if (step_cycle >= step_hold - line_follower_pkg::PWM_PERIOD) begin
                    left_high  += int'(left_pwm);
                    right_high += int'(right_pwm);
                end
                if (step_last) begin
                    compare("state", int'(expected_state), int'(state));
                    if (step_hold >= 48) begin
                        compare("left_pwm high cycles",
                                duty_for(int'(expected_state), 1'b1), left_high);
                        compare("right_pwm high cycles",
                                duty_for(int'(expected_state), 1'b0), right_high);
                    end
                end
                // watch from a short pulse until the next step has settled
                if (step_hold < line_follower_pkg::DEBOUNCE_CYCLES && step_cycle == 0) begin
                    pulse_watch = 1'b1;
                    pulse_state = last_state;
                end else if (step_hold >= line_follower_pkg::DEBOUNCE_CYCLES
                             && step_cycle >= 6) begin
                    pulse_watch = 1'b0;
                end
                if (pulse_watch && state != pulse_state) begin
                    error_count++;
                    $display("Error at %0t: state changed after a sensor pulse too short to pass",
                             $time);
                    pulse_watch = 1'b0;
                end
                if (step_cycle >= 6 && last_state == 2'(ST_STOP) && held_sensor == 3'b011) begin
                    flag = 1'b1;
                end
            end
            was_reset = 1'b0;
        end
        last_state = state;
        last_digit = digit;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== rtl/line_follower_top.sv ====
`timescale 1ns/1ps

module line_follower_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            left_track,
    input  logic                            mid_track,
    input  logic                            right_track,
    input  logic                            start_move,
    output line_follower_pkg::drive_state_t state,
    output line_follower_pkg::drive_state_t pre_state,
    output logic                            left_pwm,
    output logic                            right_pwm,
    output logic [6:0]                      display,
    output logic [3:0]                      digit
);

    // debounced sensor bits and start switch
    line_follower_pkg::sensor_t sensor;
    logic                       move_enable;

    track_sensor_sync i_track_sensor_sync (
        .clk         (clk),
        .reset       (reset),
        .left_track  (left_track),
        .mid_track   (mid_track),
        .right_track (right_track),
        .start_move  (start_move),
        .sensor      (sensor),
        .move_enable (move_enable)
    );

    tracker_fsm i_tracker_fsm (
        .clk         (clk),
        .reset       (reset),
        .sensor      (sensor),
        .move_enable (move_enable),
        .state       (state),
        .pre_state   (pre_state)
    );

    motor_pwm i_motor_pwm (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .left_pwm  (left_pwm),
        .right_pwm (right_pwm)
    );

    seven_segment i_seven_segment (
        .clk     (clk),
        .reset   (reset),
        .state   (state),
        .sensor  (sensor),
        .display (display),
        .digit   (digit)
    );

endmodule

// ==== rtl/seven_segment.sv ====
`timescale 1ns/1ps

module seven_segment (
    input  logic                            clk,
    input  logic                            reset,
    input  line_follower_pkg::drive_state_t state,
    input  line_follower_pkg::sensor_t      sensor,
    output logic [6:0]                      display,
    output logic [3:0]                      digit
);

    logic [line_follower_pkg::SCAN_DIV_BITS-1:0] scan_count;
    logic                                        scan_tick;
    // value shown on the active digit
    logic [3:0]                                  digit_value;

    // free-running divider, one tick per wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_count <= '0;
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

    assign scan_tick = &scan_count;

    // rotation right, mid, left, state; 1111 only after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digit       <= 4'b1111;
            digit_value <= 4'hf;
        end else if (scan_tick) begin
            unique case (digit)
                4'b1110: begin
                    digit       <= 4'b1101;
                    digit_value <= {3'b000, sensor[1]};
                end
                4'b1101: begin
                    digit       <= 4'b1011;
                    digit_value <= {3'b000, sensor[2]};
                end
                4'b1011: begin
                    digit       <= 4'b0111;
                    digit_value <= {2'b00, state};
                end
                default: begin
                    digit       <= 4'b1110;
                    digit_value <= {3'b000, sensor[0]};
                end
            endcase
        end
    end

    // segments gfedcba, active low
    always_comb begin
        unique case (digit_value)
            4'd0:    display = 7'b1000000;
            4'd1:    display = 7'b1111001;
            4'd2:    display = 7'b0100100;
            4'd3:    display = 7'b0110000;
            4'd4:    display = 7'b0011001;
            4'd5:    display = 7'b0010010;
            4'd6:    display = 7'b0000010;
            4'd7:    display = 7'b1111000;
            4'd8:    display = 7'b0000000;
            4'd9:    display = 7'b0010000;
            // minus sign
            4'd10:   display = 7'b0111111;
            default: display = 7'b1111111;
        endcase
    end

endmodule

// ==== rtl/motor_pwm.sv ====
`timescale 1ns/1ps

module motor_pwm (
    input  logic                            clk,
    input  logic                            reset,
    input  line_follower_pkg::drive_state_t state,
    output logic                            left_pwm,
    output logic                            right_pwm
);

    line_follower_pkg::pwm_count_t pwm_count;
    line_follower_pkg::pwm_count_t left_duty;
    line_follower_pkg::pwm_count_t right_duty;
    line_follower_pkg::pwm_count_t left_duty_sel;
    line_follower_pkg::pwm_count_t right_duty_sel;
    logic                          period_end;

    assign period_end = (pwm_count ==
                         line_follower_pkg::pwm_count_t'(line_follower_pkg::PWM_PERIOD - 1));

    // duty per drive state; the slow wheel is on the inside of the turn
    always_comb begin
        unique case (state)
            line_follower_pkg::go_straight: begin
                left_duty_sel  = line_follower_pkg::DUTY_FAST;
                right_duty_sel = line_follower_pkg::DUTY_FAST;
            end
            line_follower_pkg::turn_left: begin
                left_duty_sel  = line_follower_pkg::DUTY_SLOW;
                right_duty_sel = line_follower_pkg::DUTY_FAST;
            end
            line_follower_pkg::turn_right: begin
                left_duty_sel  = line_follower_pkg::DUTY_FAST;
                right_duty_sel = line_follower_pkg::DUTY_SLOW;
            end
            default: begin
                left_duty_sel  = '0;
                right_duty_sel = '0;
            end
        endcase
    end

    // new duty is taken as the counter wraps to zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_count  <= '0;
            left_duty  <= '0;
            right_duty <= '0;
        end else if (period_end) begin
            pwm_count  <= '0;
            left_duty  <= left_duty_sel;
            right_duty <= right_duty_sel;
        end else begin
            pwm_count <= pwm_count + 4'd1;
        end
    end

    assign left_pwm  = (pwm_count < left_duty);
    assign right_pwm = (pwm_count < right_duty);

endmodule

// ==== rtl/tracker_fsm.sv ====
`timescale 1ns/1ps

module tracker_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  line_follower_pkg::sensor_t      sensor,
    input  logic                            move_enable,
    output line_follower_pkg::drive_state_t state,
    output line_follower_pkg::drive_state_t pre_state
);

    line_follower_pkg::drive_state_t next_state;
    line_follower_pkg::black_count_t black_count;
    logic                            all_black;
    logic                            long_black;
    // set when the car left stop from 011, held until reset
    logic                            direction;

    assign all_black  = (sensor == 3'b111);
    assign long_black = (black_count > line_follower_pkg::BLACK_LIMIT);

    // latch the direction from the starting position
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            direction <= 1'b0;
        end else if (state == line_follower_pkg::stop && sensor == 3'b011) begin
            direction <= 1'b1;
        end
    end

    // consecutive all-black cycles, saturating
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            black_count <= '0;
        end else if (!all_black) begin
            black_count <= '0;
        end else if (black_count != '1) begin
            black_count <= black_count + 8'd1;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            line_follower_pkg::stop: begin
                // leave only when the start switch allows it
                if (move_enable && (sensor == 3'b110 || sensor == 3'b011)) begin
                    next_state = line_follower_pkg::go_straight;
                end
            end
            line_follower_pkg::go_straight: begin
                if (all_black) begin
                    if (long_black) begin
                        next_state = direction ? line_follower_pkg::turn_left
                                               : line_follower_pkg::turn_right;
                    end
                end else begin
                    next_state = direction ? line_follower_pkg::turn_right
                                           : line_follower_pkg::turn_left;
                end
            end
            line_follower_pkg::turn_left: begin
                if (direction != all_black) begin
                    next_state = line_follower_pkg::go_straight;
                end
            end
            line_follower_pkg::turn_right: begin
                if (direction == all_black) begin
                    next_state = line_follower_pkg::go_straight;
                end
            end
            default: begin
                next_state = line_follower_pkg::stop;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= line_follower_pkg::stop;
            pre_state <= line_follower_pkg::stop;
        end else begin
            // pre_state remembers the state that was left last
            if (next_state != state) begin
                pre_state <= state;
            end
            state <= next_state;
        end
    end

    // a start always passes through go_straight first
    no_turn_from_stop: assert property (@(posedge clk) disable iff (reset)
        (state == line_follower_pkg::stop) |=>
        (state == line_follower_pkg::stop || state == line_follower_pkg::go_straight));

endmodule

// ==== rtl/track_sensor_sync.sv ====
`timescale 1ns/1ps

module track_sensor_sync (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       left_track,
    input  logic                       mid_track,
    input  logic                       right_track,
    input  logic                       start_move,
    output line_follower_pkg::sensor_t sensor,
    output logic                       move_enable
);

    // bit 3 is start_move, bits 2:0 are left, mid, right
    logic [3:0] sync_1;
    logic [3:0] sync_2;
    logic [3:0] candidate;
    logic [2:0] agree_count;

    // two-flop synchronizer on the raw pins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= {start_move, left_track, mid_track, right_track};
            sync_2 <= sync_1;
        end
    end

    // any new sample value restarts the agreement run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            candidate   <= '0;
            agree_count <= '0;
            sensor      <= '0;
            move_enable <= 1'b0;
        end else if (sync_2 != candidate) begin
            candidate   <= sync_2;
            agree_count <= 3'd1;
        end else if (agree_count == 3'(line_follower_pkg::DEBOUNCE_CYCLES - 1)) begin
            // this sample completes the run
            {move_enable, sensor} <= candidate;
        end else begin
            agree_count <= agree_count + 3'd1;
        end
    end

    // after a debounced change the next cycle cannot change it again
    sensor_change_spacing: assert property (@(posedge clk) disable iff (reset)
        (sensor != $past(sensor)) |=> (sensor == $past(sensor)));

endmodule

// ==== rtl/line_follower_pkg.sv ====
package line_follower_pkg;

    // drive state codes
    typedef enum logic [1:0] {
        stop        = 2'b00,
        turn_right  = 2'b01,
        turn_left   = 2'b10,
        go_straight = 2'b11
    } drive_state_t;

    // ordered left, mid, right; a 1 is black
    typedef logic [2:0] sensor_t;

    // run length of consecutive all-black samples
    typedef logic [7:0] black_count_t;

    // pwm counter and duty values
    typedef logic [3:0] pwm_count_t;

    // an all-black run longer than this ends go_straight
    localparam black_count_t BLACK_LIMIT = 8'd100;

    // equal synchronized samples needed before the debounced value moves
    localparam int DEBOUNCE_CYCLES = 4;

    // wheel pwm period and duties, in clk cycles
    localparam int PWM_PERIOD = 16;
    localparam pwm_count_t DUTY_FAST = 4'd12;
    localparam pwm_count_t DUTY_SLOW = 4'd4;

    // display advances one digit every 2**SCAN_DIV_BITS cycles
    localparam int SCAN_DIV_BITS = 4;

endpackage
